/* Makefile */
VERILATOR ?= verilator
TOP       ?= cam_capture_tb
FLIST     ?= flist.f
BUILD_DIR ?= build
VFLAGS    ?=

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the result"
	@echo "  clean  remove the $(BUILD_DIR) folder"
	@echo "  help   list these targets"

test:
	$(VERILATOR) --binary --assert --timing --top-module $(TOP) \
		-f $(FLIST) -Mdir $(BUILD_DIR) $(VFLAGS)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST OK$$"

clean:
	rm -rf $(BUILD_DIR)

/* flist.f */
+incdir+logic
logic/video_pkg.sv
logic/buffer_pkg.sv
logic/pixel_stream_if.sv
logic/video_unpack.sv
logic/pixel_fifo.sv
logic/overflow_alarm.sv
logic/line_buffer.sv
logic/cam_capture_top.sv
sim/cam_capture_sva.sv
sim/cam_capture_tb.sv

/* logic/buffer_pkg.sv */
package buffer_pkg;

    // stored pixel, red in the top bits
    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } rgb565_t;

    typedef enum logic [1:0] {
        idle       = 2'b00,
        wait_vsync = 2'b01,
        wait_line  = 2'b10,
        read_line  = 2'b11
    } capture_state_t;

endpackage

/* logic/cam_capture_top.sv */
`timescale 1ns/10ps

`include "capture_consts.svh"

module cam_capture_top #(
    parameter int  H_ACT      = `CAM_H_ACT,
    parameter int  V_ACT      = `CAM_V_ACT,
    parameter int  ALARM_HOLD = `CAM_ALARM_HOLD,
    localparam int FIFO_DEPTH = `CAM_FIFO_LINES * H_ACT,
    localparam int CNT_W      = $clog2(FIFO_DEPTH + 1),
    localparam int ROW_W      = $clog2(V_ACT + 1)
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  video_pkg::cam_pack_t cam_pack,
    input  logic                 trig,
    output logic                 acquire,
    input  logic                 read_en,
    output logic [15:0]          cam_data,
    output logic [ROW_W-1:0]     cam_row,
    output logic                 error
);

    pixel_stream_if vid ();

    logic                fifo_wr_en;
    buffer_pkg::rgb565_t fifo_wr_data;
    logic                fifo_flush;
    logic [CNT_W-1:0]    fifo_count;
    logic                fifo_full;

    video_unpack u_unpack (
        .pack (cam_pack),
        .vid  (vid.src)
    );

    line_buffer #(
        .H_ACT (H_ACT),
        .V_ACT (V_ACT)
    ) u_line_buffer (
        .clk        (clk),
        .rstn       (rstn),
        .vid        (vid.snk),
        .trig       (trig),
        .acquire    (acquire),
        .read_en    (read_en),
        .fifo_count (fifo_count),
        .fifo_full  (fifo_full),
        .wr_en      (fifo_wr_en),
        .wr_data    (fifo_wr_data),
        .flush      (fifo_flush),
        .cam_row    (cam_row)
    );

    pixel_fifo #(
        .DEPTH     (FIFO_DEPTH),
        .payload_t (buffer_pkg::rgb565_t)
    ) u_fifo (
        .clk     (clk),
        .rstn    (rstn),
        .flush   (fifo_flush),
        .wr_en   (fifo_wr_en),
        .wr_data (fifo_wr_data),
        .rd_en   (read_en),
        .rd_data (cam_data),
        .count   (fifo_count),
        .full    (fifo_full)
    );

    overflow_alarm #(
        .HOLD (ALARM_HOLD)
    ) u_alarm (
        .clk   (clk),
        .rstn  (rstn),
        .trip  (fifo_full),
        .error (error)
    );

endmodule

/* logic/capture_consts.svh */
`ifndef CAPTURE_CONSTS_SVH
`define CAPTURE_CONSTS_SVH

// packed camera bus, one clock bit, vsync, de, 22 reserved bits and 24 colour bits
`define CAM_PACK_W 49

// active video size
`define CAM_H_ACT 1280
`define CAM_V_ACT 720

// cycles the overflow error stays up after the last full cycle
`define CAM_ALARM_HOLD 37500000

// line fifo holds this many active lines
`define CAM_FIFO_LINES 2

`endif

/* logic/line_buffer.sv */
`timescale 1ns/10ps

`include "capture_consts.svh"

module line_buffer #(
    parameter int  H_ACT = `CAM_H_ACT,
    parameter int  V_ACT = `CAM_V_ACT,
    localparam int CNT_W = $clog2(`CAM_FIFO_LINES * H_ACT + 1),
    localparam int ROW_W = $clog2(V_ACT + 1)
) (
    input  logic                clk,
    input  logic                rstn,
    pixel_stream_if.snk         vid,
    input  logic                trig,
    output logic                acquire,
    input  logic                read_en,
    input  logic [CNT_W-1:0]    fifo_count,
    input  logic                fifo_full,
    output logic                wr_en,
    output buffer_pkg::rgb565_t wr_data,
    output logic                flush,
    output logic [ROW_W-1:0]    cam_row
);

    localparam int COL_W = $clog2(H_ACT + 1);

    buffer_pkg::capture_state_t state;
    buffer_pkg::capture_state_t state_nxt;

    logic [COL_W-1:0] col;
    logic [ROW_W-1:0] row;
    logic             write_state;
    logic             line_ready;
    logic             pop;
    logic             col_end;
    logic             row_end;
    logic             pop_last;

    assign write_state = (state == buffer_pkg::wait_line) || (state == buffer_pkg::read_line);
    assign line_ready  = (fifo_count >= CNT_W'(H_ACT));
    assign pop         = read_en && (state == buffer_pkg::read_line);
    assign col_end     = (col == COL_W'(H_ACT - 1));
    assign row_end     = (row == ROW_W'(V_ACT - 1));
    assign pop_last    = pop && col_end;

    // truncate to 565
    assign wr_data = '{
        r: vid.pix.r[7:3],
        g: vid.pix.g[7:2],
        b: vid.pix.b[7:3]
    };

    assign wr_en = vid.de && write_state && !fifo_full;

    // keep the fifo empty while not writing, and drop leftovers at each row end
    assign flush   = !write_state || pop_last;
    assign cam_row = row;

    always_comb begin
        state_nxt = state;
        case (state)
            buffer_pkg::idle: begin
                if (trig) begin
                    state_nxt = buffer_pkg::wait_vsync;
                end
            end
            buffer_pkg::wait_vsync: begin
                if (vid.vsync) begin
                    state_nxt = buffer_pkg::wait_line;
                end
            end
            buffer_pkg::wait_line: begin
                if (line_ready) begin
                    state_nxt = buffer_pkg::read_line;
                end
            end
            buffer_pkg::read_line: begin
                if (pop_last) begin
                    state_nxt = row_end ? buffer_pkg::idle : buffer_pkg::wait_line;
                end
            end
            default: begin
                state_nxt = buffer_pkg::idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state   <= buffer_pkg::idle;
            acquire <= 1'b0;
        end else begin
            state   <= state_nxt;
            acquire <= (state_nxt == buffer_pkg::read_line);
        end
    end

    // column and row of the fifo head
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            col <= '0;
            row <= '0;
        end else if (state == buffer_pkg::idle) begin
            col <= '0;
            row <= '0;
        end else if (pop) begin
            if (col_end) begin
                col <= '0;
                row <= row_end ? '0 : row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

endmodule

/* logic/overflow_alarm.sv */
`timescale 1ns/10ps

`include "capture_consts.svh"

module overflow_alarm #(
    parameter int HOLD = `CAM_ALARM_HOLD
) (
    input  logic clk,
    input  logic rstn,
    input  logic trip,
    output logic error
);

    localparam int CNT_W = $clog2(HOLD + 1);

    logic [CNT_W-1:0] hold_cnt;

    // reload with HOLD-1 so error drops HOLD edges after the last trip cycle
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            hold_cnt <= '0;
            error    <= 1'b0;
        end else begin
            if (trip) begin
                hold_cnt <= CNT_W'(HOLD - 1);
            end else if (hold_cnt != '0) begin
                hold_cnt <= hold_cnt - 1'b1;
            end
            error <= trip || (hold_cnt != '0);
        end
    end

endmodule

/* logic/pixel_fifo.sv */
`timescale 1ns/10ps

module pixel_fifo #(
    parameter int  DEPTH     = 16,
    parameter type payload_t = logic [15:0],
    localparam int CNT_W     = $clog2(DEPTH + 1)
) (
    input  logic             clk,
    input  logic             rstn,
    input  logic             flush,
    input  logic             wr_en,
    input  payload_t         wr_data,
    input  logic             rd_en,
    output payload_t         rd_data,
    output logic [CNT_W-1:0] count,
    output logic             full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [PTR_W-1:0] LAST = PTR_W'(DEPTH - 1);

    payload_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             do_wr;
    logic             do_rd;

    assign full  = (count == CNT_W'(DEPTH));
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && (count != '0);

    // first word fall through, head is always visible
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            // flush wins over any read or write in the same cycle
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

/* logic/pixel_stream_if.sv */
`timescale 1ns/10ps

interface pixel_stream_if;

    logic              vsync;
    logic              de;
    video_pkg::rgb888_t pix;

    modport src (
        output vsync,
        output de,
        output pix
    );

    modport snk (
        input vsync,
        input de,
        input pix
    );

endinterface

/* logic/video_pkg.sv */
`include "capture_consts.svh"

package video_pkg;

    // raw receiver bus, bit positions
    //   [48]    camera clock (not used here)
    //   [47]    vsync
    //   [46]    data enable
    //   [45:24] reserved
    //   [23:16] red
    //   [15:8]  green
    //   [7:0]   blue
    typedef logic [`CAM_PACK_W-1:0] cam_pack_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb888_t;

endpackage

/* logic/video_unpack.sv */
`timescale 1ns/10ps

module video_unpack (
    input  video_pkg::cam_pack_t pack,
    pixel_stream_if.src          vid
);

    localparam int VSYNC_BIT = 47;
    localparam int DE_BIT    = 46;
    localparam int R_LSB     = 16;
    localparam int G_LSB     = 8;
    localparam int B_LSB     = 0;

    // bit 48 carries the camera clock, everything here runs on clk
    assign vid.vsync = pack[VSYNC_BIT];
    assign vid.de    = pack[DE_BIT];

    assign vid.pix = '{
        r: pack[R_LSB +: 8],
        g: pack[G_LSB +: 8],
        b: pack[B_LSB +: 8]
    };

endmodule

/* sim/cam_capture_sva.sv */
`timescale 1ns/10ps

module cam_capture_sva #(
    parameter int H_ACT = 8,
    parameter int CNT_W = 5
) (
    input logic                       clk,
    input logic                       rstn,
    input buffer_pkg::capture_state_t state,
    input logic                       acquire,
    input logic [CNT_W-1:0]           fifo_count,
    input logic                       read_en
);

    logic in_write;

    assign in_write = (state == buffer_pkg::wait_line) || (state == buffer_pkg::read_line);

    // a line is offered only once it sits complete in the fifo
    acquire_after_full_line: assert property (
        @(posedge clk) disable iff (!rstn)
        $rose(acquire) |-> ($past(fifo_count) >= CNT_W'(H_ACT))
    ) else $error("acquire rose before a full line was stored");

    acquire_has_pixels: assert property (
        @(posedge clk) disable iff (!rstn)
        acquire |-> (fifo_count != '0)
    ) else $error("acquire high while the fifo is empty");

    // nothing is kept outside wait_line and read_line
    fifo_empty_outside_write_states: assert property (
        @(posedge clk) disable iff (!rstn)
        !in_write |-> (fifo_count == '0)
    ) else $error("fifo holds pixels outside the write states");

    read_en_needs_acquire: assert property (
        @(posedge clk) disable iff (!rstn)
        read_en |-> acquire
    ) else $error("read strobe while acquire is low");

endmodule

bind line_buffer cam_capture_sva #(
    .H_ACT (H_ACT),
    .CNT_W (CNT_W)
) u_sva (
    .clk        (clk),
    .rstn       (rstn),
    .state      (state),
    .acquire    (acquire),
    .fifo_count (fifo_count),
    .read_en    (read_en)
);

/* sim/cam_capture_tb.sv */
`timescale 1ns/10ps

`include "capture_consts.svh"

module cam_capture_tb;

    localparam int H_ACT      = 8;
    localparam int V_ACT      = 4;
    localparam int ALARM_HOLD = 16;
    localparam int DEPTH      = `CAM_FIFO_LINES * H_ACT;
    localparam int ROW_W      = $clog2(V_ACT + 1);
    localparam int TIMEOUT    = 200;

    logic                 clk;
    logic                 rstn;
    video_pkg::cam_pack_t cam_pack;
    logic                 trig;
    logic                 acquire;
    logic                 read_en;
    logic [15:0]          cam_data;
    logic [ROW_W-1:0]     cam_row;
    logic                 error;

    integer      seed;
    logic [15:0] exp_q[$];
    logic        writes_open;

    cam_capture_top #(
        .H_ACT      (H_ACT),
        .V_ACT      (V_ACT),
        .ALARM_HOLD (ALARM_HOLD)
    ) dut0 (
        .clk      (clk),
        .rstn     (rstn),
        .cam_pack (cam_pack),
        .trig     (trig),
        .acquire  (acquire),
        .read_en  (read_en),
        .cam_data (cam_data),
        .cam_row  (cam_row),
        .error    (error)
    );

    always #20 clk = ~clk;

    // inputs change and outputs are sampled 2 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic stop_on_error();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        assert (expected == actual) else begin
            $display("CHECK FAILED at %0t ns: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
            stop_on_error();
        end
    endtask

    task automatic fail_plain(string what);
        $display("%s (at %0t ns)", what, $time);
        stop_on_error();
    endtask

    // keep the top bits of each colour, red highest
    function automatic logic [15:0] to_565(logic [23:0] rgb);
        return {rgb[23:19], rgb[15:10], rgb[7:3]};
    endfunction

    task automatic bus_idle();
        cam_pack[47] = 1'b0;
        cam_pack[46] = 1'b0;
    endtask

    // one bus cycle; the camera clock bit just toggles
    task automatic drive_bus(logic vs, logic de, logic [23:0] rgb);
        video_pkg::cam_pack_t p;
        p       = '0;
        p[48]   = ~cam_pack[48];
        p[47]   = vs;
        p[46]   = de;
        p[23:0] = rgb;
        cam_pack = p;
        if (de && writes_open && exp_q.size() < DEPTH) begin
            exp_q.push_back(to_565(rgb));
        end
        step();
    endtask

    task automatic send_row(int npix);
        logic [31:0] word;
        for (int i = 0; i < npix; i++) begin
            word = $random(seed);
            drive_bus(1'b0, 1'b1, word[23:0]);
        end
        bus_idle();
    endtask

    task automatic arm_capture();
        exp_q.delete();
        trig = 1'b1;
        step();
        trig = 1'b0;
        drive_bus(1'b1, 1'b0, 24'h0);
        bus_idle();
        writes_open = 1'b1;
    endtask

    task automatic wait_for_acquire();
        int n;
        n = 0;
        while (!acquire) begin
            step();
            n++;
            if (n > TIMEOUT) begin
                fail_plain("acquire never rose after a full line was sent");
            end
        end
    endtask

    task automatic read_row(int row);
        wait_for_acquire();
        if (exp_q.size() < H_ACT) begin
            fail_plain("reference model holds less than one line of pixels");
        end
        for (int i = 0; i < H_ACT; i++) begin
            check_value("cam_data", 32'(exp_q[i]), 32'(cam_data));
            check_value("cam_row", row, 32'(cam_row));
            read_en = 1'b1;
            step();
        end
        read_en = 1'b0;
        // the last pop flushes the fifo, leftovers included
        exp_q.delete();
        if (row == V_ACT - 1) begin
            writes_open = 1'b0;
        end
        check_value("acquire", 0, 32'(acquire));
        check_value("cam_row", (row + 1) % V_ACT, 32'(cam_row));
    endtask

    task automatic expect_no_acquire(int cycles);
        for (int i = 0; i < cycles; i++) begin
            step();
            check_value("acquire", 0, 32'(acquire));
        end
    endtask

    task automatic capture_frame();
        for (int r = 0; r < V_ACT; r++) begin
            send_row(H_ACT);
            read_row(r);
        end
    endtask

    task automatic test_reset_state();
        check_value("acquire", 0, 32'(acquire));
        check_value("error", 0, 32'(error));
        check_value("cam_row", 0, 32'(cam_row));
    endtask

    task automatic test_unarmed();
        drive_bus(1'b1, 1'b1, 24'h123456);
        send_row(2 * H_ACT);
        expect_no_acquire(3 * H_ACT);
    endtask

    task automatic test_full_frame();
        arm_capture();
        capture_frame();
        // writes are closed again, so a further row must not be offered
        send_row(H_ACT);
        expect_no_acquire(2 * H_ACT);
    endtask

    task automatic test_extra_pixels();
        arm_capture();
        send_row(H_ACT + 3);
        read_row(0);
        for (int r = 1; r < V_ACT; r++) begin
            send_row(H_ACT);
            read_row(r);
        end
    endtask

    task automatic test_rearm();
        arm_capture();
        capture_frame();
    endtask

    task automatic test_overflow();
        int n;
        arm_capture();
        send_row(20);
        n = 0;
        while (!error) begin
            step();
            n++;
            if (n > TIMEOUT) begin
                fail_plain("error never rose after the fifo overflowed");
            end
        end
        for (int i = 0; i < ALARM_HOLD; i++) begin
            step();
            check_value("error", 1, 32'(error));
        end
        read_row(0);
        // error falls HOLD edges after the first pop ends the last full cycle
        // read_row has already stepped past H_ACT-1 of those edges
        n = 0;
        while (error) begin
            step();
            n++;
            if (n > TIMEOUT) begin
                fail_plain("error stayed high long after the overflow cleared");
            end
        end
        check_value("error hold cycles", ALARM_HOLD - (H_ACT - 1), n);
    endtask

    initial begin
        seed        = 32'h153c3270;
        clk         = 1'b0;
        rstn        = 1'b0;
        trig        = 1'b0;
        read_en     = 1'b0;
        cam_pack    = '0;
        writes_open = 1'b0;
        repeat (10) @(posedge clk);
        #2;
        rstn = 1'b1;
        step();

        test_reset_state();
        test_unarmed();
        test_full_frame();
        test_extra_pixels();
        test_rearm();
        test_overflow();

        $display("TEST OK");
        $finish;
    end

endmodule
